// ==== br_pkg.sv ====
`default_nettype none

package br_pkg;

  // datapath width for pcs, operands and immediates
  localparam int XLEN = 32;

  // direct-mapped btb, indexed by pc[5:2] and tagged by pc[31:6]
  localparam int BTB_ENTRIES = 16;
  localparam int BTB_IDX_W   = 4;
  localparam int BTB_TAG_W   = 26;

  // comparison selected in the resolve stage
  typedef enum logic [1:0] {
    CMP_EQ  = 2'd0,  // beq, bne
    CMP_LT  = 2'd1,  // blt, bge
    CMP_LTU = 2'd2   // bltu, bgeu
  } br_cmp_e;

  // two-bit saturating counter held in every btb entry
  typedef enum logic [1:0] {
    STRONG_NT = 2'd0,
    WEAK_NT   = 2'd1,
    WEAK_T    = 2'd2,
    STRONG_T  = 2'd3
  } br_ctr_e;

  // funct3 field of the conditional branch opcode
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  // 010 and 011 have no branch meaning and are rejected at issue

endpackage

`default_nettype wire

// ==== br_predict.sv ====
`timescale 1ns/1ps
`default_nettype none

module br_predict import br_pkg::*; (
  input  logic            CLK,
  input  logic            nRST,
  input  logic [XLEN-1:0] lookup_pc,
  input  logic            btb_we,
  input  logic [XLEN-1:0] btb_pc,
  input  logic [XLEN-1:0] btb_target,
  input  logic            btb_taken,
  output logic            pred_taken,
  output logic [XLEN-1:0] pred_target
);

  // per-entry valid, tag, target and counter
  logic [BTB_ENTRIES-1:0] valid_q;
  logic [BTB_TAG_W-1:0]   tag_q    [BTB_ENTRIES];
  logic [XLEN-1:0]        target_q [BTB_ENTRIES];
  br_ctr_e                ctr_q    [BTB_ENTRIES];

  // lookup side
  logic [BTB_IDX_W-1:0] rd_idx;
  logic [BTB_TAG_W-1:0] rd_tag;
  logic                 rd_hit;
  br_ctr_e              rd_ctr;

  // write side
  logic [BTB_IDX_W-1:0] wr_idx;
  logic [BTB_TAG_W-1:0] wr_tag;
  logic                 wr_hit;

  // move the counter one step toward the resolved outcome, saturating at both ends
  function automatic br_ctr_e ctr_step(input br_ctr_e cur, input logic taken);
    br_ctr_e nxt;
    nxt = cur;
    case (cur)
      STRONG_NT: nxt = taken ? WEAK_NT  : STRONG_NT;
      WEAK_NT:   nxt = taken ? WEAK_T   : STRONG_NT;
      WEAK_T:    nxt = taken ? STRONG_T : WEAK_NT;
      STRONG_T:  nxt = taken ? STRONG_T : WEAK_T;
      default:   nxt = cur;
    endcase
    return nxt;
  endfunction

  assign rd_idx = lookup_pc[2 +: BTB_IDX_W];
  assign rd_tag = lookup_pc[XLEN-1 -: BTB_TAG_W];
  assign rd_hit = valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);
  assign rd_ctr = ctr_q[rd_idx];

  always_comb begin
    pred_taken  = 1'b0;
    pred_target = lookup_pc + 32'd4;  // fall through when missing or weakly not taken
    if (rd_hit && (rd_ctr == WEAK_T || rd_ctr == STRONG_T)) begin
      pred_taken  = 1'b1;
      pred_target = target_q[rd_idx];
    end
  end

  assign wr_idx = btb_pc[2 +: BTB_IDX_W];
  assign wr_tag = btb_pc[XLEN-1 -: BTB_TAG_W];
  assign wr_hit = valid_q[wr_idx] && (tag_q[wr_idx] == wr_tag);

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      valid_q <= '0;
    end else if (btb_we) begin
      valid_q[wr_idx] <= 1'b1;  // an allocation on a miss also lands here
    end
  end

  // a matching entry trains its counter, anything else at the index is replaced
  always_ff @(posedge CLK) begin
    if (btb_we) begin
      target_q[wr_idx] <= btb_target;
      if (wr_hit) begin
        ctr_q[wr_idx] <= ctr_step(ctr_q[wr_idx], btb_taken);
      end else begin
        tag_q[wr_idx] <= wr_tag;
        ctr_q[wr_idx] <= btb_taken ? WEAK_T : WEAK_NT;
      end
    end
  end

endmodule

`default_nettype wire

// ==== br_operand.sv ====
`timescale 1ns/1ps
`default_nettype none

module br_operand import br_pkg::*; (
  input  logic            CLK,
  input  logic            nRST,
  input  logic            issue,
  input  logic [XLEN-1:0] issue_pc,
  input  logic [2:0]      issue_funct3,
  input  logic [XLEN-1:0] issue_a,
  input  logic [XLEN-1:0] issue_b,
  input  logic [XLEN-1:0] issue_imm,
  input  logic            pred_taken,
  input  logic            retire,
  output logic            branch,
  output br_cmp_e         branch_type,
  output logic            branch_gate_sel,
  output logic [XLEN-1:0] current_pc,
  output logic [XLEN-1:0] reg_a,
  output logic [XLEN-1:0] reg_b,
  output logic [XLEN-1:0] imm,
  output logic            predicted_outcome
);

  logic    dec_ok;   // funct3 names a conditional branch
  br_cmp_e dec_cmp;
  logic    dec_inv;  // outcome is the negated compare
  logic    capture;

  always_comb begin
    dec_ok  = 1'b1;
    dec_cmp = CMP_EQ;
    dec_inv = 1'b0;
    case (issue_funct3)
      F3_BEQ:  dec_cmp = CMP_EQ;
      F3_BNE:  begin dec_cmp = CMP_EQ;  dec_inv = 1'b1; end
      F3_BLT:  dec_cmp = CMP_LT;
      F3_BGE:  begin dec_cmp = CMP_LT;  dec_inv = 1'b1; end
      F3_BLTU: dec_cmp = CMP_LTU;
      F3_BGEU: begin dec_cmp = CMP_LTU; dec_inv = 1'b1; end
      default: dec_ok = 1'b0;
    endcase
  end

  // only one branch can wait here, a second issue is dropped
  assign capture = issue && !branch && dec_ok;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      branch <= 1'b0;
    end else if (capture) begin
      branch <= 1'b1;
    end else if (retire) begin
      branch <= 1'b0;
    end
  end

  always_ff @(posedge CLK) begin
    if (capture) begin
      branch_type       <= dec_cmp;
      branch_gate_sel   <= dec_inv;
      current_pc        <= issue_pc;
      reg_a             <= issue_a;
      reg_b             <= issue_b;
      imm               <= issue_imm;
      predicted_outcome <= pred_taken;  // prediction seen in the issue cycle
    end
  end

endmodule

`default_nettype wire

// ==== fu_branch.sv ====
`timescale 1ns/1ps
`default_nettype none

module fu_branch import br_pkg::*; (
  input  logic            CLK,
  input  logic            nRST,
  input  logic            branch,
  input  logic            enable,
  input  br_cmp_e         branch_type,
  input  logic            branch_gate_sel,
  input  logic [XLEN-1:0] current_pc,
  input  logic [XLEN-1:0] reg_a,
  input  logic [XLEN-1:0] reg_b,
  input  logic [XLEN-1:0] imm,
  input  logic            predicted_outcome,
  output logic            branch_outcome,
  output logic            misprediction,
  output logic [XLEN-1:0] correct_pc,
  output logic            update_btb,
  output logic [XLEN-1:0] update_pc,
  output logic [XLEN-1:0] branch_target
);

  logic            cmp_true;    // base relation before the bne/bge/bgeu inversion
  logic            actual_outcome;
  logic [XLEN-1:0] taken_pc;
  logic [XLEN-1:0] fall_pc;
  logic            btb_updated; // set once this held branch has sent its update

  // cleared as soon as the operand stage lets the branch go
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      btb_updated <= 1'b0;
    end else if (!branch) begin
      btb_updated <= 1'b0;
    end else if (enable && !btb_updated) begin
      btb_updated <= 1'b1;
    end
  end

  always_comb begin
    case (branch_type)
      CMP_EQ:  cmp_true = (reg_a == reg_b);
      CMP_LT:  cmp_true = ($signed(reg_a) < $signed(reg_b));
      CMP_LTU: cmp_true = (reg_a < reg_b);
      default: cmp_true = 1'b0;
    endcase
  end

  assign taken_pc       = current_pc + imm;
  assign fall_pc        = current_pc + 32'd4;
  assign actual_outcome = cmp_true ^ branch_gate_sel;

  always_comb begin
    branch_outcome = 1'b0;
    misprediction  = 1'b0;
    correct_pc     = fall_pc;
    update_btb     = 1'b0;
    update_pc      = '0;
    branch_target  = '0;
    if (branch) begin
      branch_outcome = actual_outcome;
      misprediction  = (actual_outcome != predicted_outcome);
      correct_pc     = actual_outcome ? taken_pc : fall_pc;
      // enable paces the update, the guard keeps it to one per branch
      update_btb     = enable && !btb_updated;
      update_pc      = current_pc;     // btb is indexed by the branch's own pc
      branch_target  = taken_pc;       // stored even for not taken outcomes
    end
  end

endmodule

`default_nettype wire

// ==== br_update.sv ====
`timescale 1ns/1ps
`default_nettype none

module br_update import br_pkg::*; (
  input  logic            CLK,
  input  logic            nRST,
  input  logic            update_btb,
  input  logic            misprediction,
  input  logic            branch_outcome,
  input  logic [XLEN-1:0] correct_pc,
  input  logic [XLEN-1:0] update_pc,
  input  logic [XLEN-1:0] branch_target,
  output logic            resolved,
  output logic            resolved_taken,
  output logic [XLEN-1:0] resolved_pc,
  output logic            redirect,
  output logic [XLEN-1:0] redirect_pc,
  output logic            btb_we,
  output logic [XLEN-1:0] btb_pc,
  output logic [XLEN-1:0] btb_target,
  output logic            btb_taken
);

  logic            taken_q;
  logic [XLEN-1:0] next_pc_q;   // corrected next pc of the resolved branch
  logic [XLEN-1:0] br_pc_q;
  logic [XLEN-1:0] target_q;

  // pulses last exactly one cycle since update_btb is itself a single cycle
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      resolved <= 1'b0;
      redirect <= 1'b0;
    end else begin
      resolved <= update_btb;
      redirect <= update_btb && misprediction;
    end
  end

  always_ff @(posedge CLK) begin
    if (update_btb) begin
      taken_q   <= branch_outcome;
      next_pc_q <= correct_pc;
      br_pc_q   <= update_pc;
      target_q  <= branch_target;
    end
  end

  // report and redirect share the captured next pc
  assign resolved_taken = taken_q;
  assign resolved_pc    = next_pc_q;
  assign redirect_pc    = next_pc_q;

  // the predictor is written on the edge that closes the report cycle
  assign btb_we     = resolved;
  assign btb_pc     = br_pc_q;
  assign btb_target = target_q;
  assign btb_taken  = taken_q;

endmodule

`default_nettype wire

// ==== br_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module br_top import br_pkg::*; (
  input  logic            CLK,
  input  logic            nRST,
  input  logic            issue,
  input  logic [XLEN-1:0] issue_pc,
  input  logic [2:0]      issue_funct3,
  input  logic [XLEN-1:0] issue_a,
  input  logic [XLEN-1:0] issue_b,
  input  logic [XLEN-1:0] issue_imm,
  input  logic            enable,
  input  logic            retire,
  output logic            pred_taken,
  output logic [XLEN-1:0] pred_target,
  output logic            busy,
  output logic            resolved,
  output logic            resolved_taken,
  output logic [XLEN-1:0] resolved_pc,
  output logic            redirect,
  output logic [XLEN-1:0] redirect_pc
);

  // operand stage to resolve stage
  br_cmp_e         branch_type;
  logic            branch_gate_sel;
  logic [XLEN-1:0] current_pc;
  logic [XLEN-1:0] reg_a;
  logic [XLEN-1:0] reg_b;
  logic [XLEN-1:0] imm;
  logic            predicted_outcome;

  // resolve stage to update stage
  logic            update_btb;
  logic            misprediction;
  logic            branch_outcome;
  logic [XLEN-1:0] correct_pc;
  logic [XLEN-1:0] update_pc;
  logic [XLEN-1:0] branch_target;

  // update stage back to the btb
  logic            btb_we;
  logic [XLEN-1:0] btb_pc;
  logic [XLEN-1:0] btb_target;
  logic            btb_taken;

  br_predict u_predict (
    .CLK, .nRST, .lookup_pc(issue_pc), .btb_we, .btb_pc, .btb_target, .btb_taken,
    .pred_taken, .pred_target
  );

  br_operand u_operand (
    .CLK, .nRST, .issue, .issue_pc, .issue_funct3, .issue_a, .issue_b, .issue_imm,
    .pred_taken, .retire, .branch(busy), .branch_type, .branch_gate_sel, .current_pc,
    .reg_a, .reg_b, .imm, .predicted_outcome
  );

  fu_branch u_fu_branch (
    .CLK, .nRST, .branch(busy), .enable, .branch_type, .branch_gate_sel, .current_pc,
    .reg_a, .reg_b, .imm, .predicted_outcome, .branch_outcome, .misprediction,
    .correct_pc, .update_btb, .update_pc, .branch_target
  );

  br_update u_update (
    .CLK, .nRST, .update_btb, .misprediction, .branch_outcome, .correct_pc, .update_pc,
    .branch_target, .resolved, .resolved_taken, .resolved_pc, .redirect, .redirect_pc,
    .btb_we, .btb_pc, .btb_target, .btb_taken
  );

endmodule

`default_nettype wire

// ==== tb_br_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_br_top import br_pkg::*; ();

  logic            CLK;
  logic            nRST;
  logic            issue;
  logic [XLEN-1:0] issue_pc;
  logic [2:0]      issue_funct3;
  logic [XLEN-1:0] issue_a;
  logic [XLEN-1:0] issue_b;
  logic [XLEN-1:0] issue_imm;
  logic            enable;
  logic            retire;
  logic            pred_taken;
  logic [XLEN-1:0] pred_target;
  logic            busy;
  logic            resolved;
  logic            resolved_taken;
  logic [XLEN-1:0] resolved_pc;
  logic            redirect;
  logic [XLEN-1:0] redirect_pc;

  typedef struct packed {
    logic [XLEN-1:0] pc;
    logic [2:0]      f3;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] imm;
    logic [3:0]      dly;    // cycles with enable low before it rises
    logic            ret;    // retire at the end of the row
    logic            taken;  // expected outcome of a captured branch
  } row_t;

  row_t rows[$];
  int   errors;
  int   rows_ok;
  int   rows_bad;
  int   cycles;
  int   limit;
  logic held;  // a branch is still waiting in the operand stage

  // reference btb state
  logic [BTB_ENTRIES-1:0] m_valid;
  logic [BTB_TAG_W-1:0]   m_tag [BTB_ENTRIES];
  logic [XLEN-1:0]        m_tgt [BTB_ENTRIES];
  logic [1:0]             m_ctr [BTB_ENTRIES];

  br_top DUT (.*);

  initial begin
    CLK = 1'b0;
    forever #2 CLK = ~CLK;
  end

  always @(posedge CLK) begin
    cycles = cycles + 1;
    if (cycles > limit) begin
      $display("timeout: the run went past %0d cycles without finishing", limit);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  task automatic expect_bit(input string name, input logic exp, input logic act);
    assert (act === exp) else begin
      $display("[FAIL] %s expected 0x%0h actual 0x%0h", name, exp, act);
      errors++;
    end
  endtask

  task automatic expect_word(input string name, input logic [XLEN-1:0] exp,
                             input logic [XLEN-1:0] act);
    assert (act === exp) else begin
      $display("[FAIL] %s expected 0x%08h actual 0x%08h", name, exp, act);
      errors++;
    end
  endtask

  function automatic void add_row(input logic [XLEN-1:0] pc, input logic [2:0] f3,
                                  input logic [XLEN-1:0] a, input logic [XLEN-1:0] b,
                                  input logic [XLEN-1:0] imm, input logic [3:0] dly,
                                  input logic ret, input logic taken);
    row_t row;
    row.pc    = pc;
    row.f3    = f3;
    row.a     = a;
    row.b     = b;
    row.imm   = imm;
    row.dly   = dly;
    row.ret   = ret;
    row.taken = taken;
    rows.push_back(row);
  endfunction

  // conditional branch compare rules with the signed order taken from the sign bits
  function automatic logic ref_outcome(input logic [2:0] f3, input logic [XLEN-1:0] a,
                                       input logic [XLEN-1:0] b);
    logic lt_s;
    logic lt_u;
    logic res;
    lt_u = a < b;
    lt_s = (a[XLEN-1] != b[XLEN-1]) ? a[XLEN-1] : lt_u;
    case (f3)
      F3_BEQ:  res = (a == b);
      F3_BNE:  res = (a != b);
      F3_BLT:  res = lt_s;
      F3_BGE:  res = !lt_s;
      F3_BLTU: res = lt_u;
      F3_BGEU: res = !lt_u;
      default: res = 1'b0;
    endcase
    return res;
  endfunction

  function automatic void model_predict(input logic [XLEN-1:0] pc, output logic taken,
                                        output logic [XLEN-1:0] target);
    logic [BTB_IDX_W-1:0] idx;
    idx    = pc[5:2];
    taken  = 1'b0;
    target = pc + 32'd4;
    if (m_valid[idx] && m_tag[idx] == pc[31:6] && m_ctr[idx] >= 2'd2) begin
      taken  = 1'b1;
      target = m_tgt[idx];
    end
  endfunction

  function automatic void model_update(input logic [XLEN-1:0] pc,
                                       input logic [XLEN-1:0] target, input logic taken);
    logic [BTB_IDX_W-1:0] idx;
    idx = pc[5:2];
    if (m_valid[idx] && m_tag[idx] == pc[31:6]) begin
      if (taken && m_ctr[idx] != 2'd3) m_ctr[idx] = m_ctr[idx] + 2'd1;
      else if (!taken && m_ctr[idx] != 2'd0) m_ctr[idx] = m_ctr[idx] - 2'd1;
    end else begin
      m_valid[idx] = 1'b1;                  // new or replaced entry starts weak
      m_tag[idx]   = pc[31:6];
      m_ctr[idx]   = taken ? 2'd2 : 2'd1;
    end
    m_tgt[idx] = target;
  endfunction

  task automatic run_row(input int r, input row_t row);
    logic            cap;
    logic            exp_pt;
    logic [XLEN-1:0] exp_tgt;
    logic            taken;
    logic [XLEN-1:0] next_pc;
    int              err0;
    int              i;
    err0  = errors;
    cap   = (row.f3 != 3'b010) && (row.f3 != 3'b011) && !held;
    taken = ref_outcome(row.f3, row.a, row.b);
    model_predict(row.pc, exp_pt, exp_tgt);
    next_pc = taken ? row.pc + row.imm : row.pc + 32'd4;
    assert (!cap || taken == row.taken) else begin
      $display("row %0d: table outcome disagrees with the compare rules", r);
      errors++;
    end
    @(posedge CLK);
    issue        <= 1'b1;
    issue_pc     <= row.pc;
    issue_funct3 <= row.f3;
    issue_a      <= row.a;
    issue_b      <= row.b;
    issue_imm    <= row.imm;
    @(negedge CLK);
    expect_bit("pred_taken", exp_pt, pred_taken);  // lookup is combinational
    expect_word("pred_target", exp_tgt, pred_target);
    @(posedge CLK);
    issue <= 1'b0;
    @(negedge CLK);
    expect_bit("busy", cap || held, busy);
    for (i = 0; i < int'(row.dly); i++) begin
      @(posedge CLK);
      // a stray issue while the stage is full must not touch the held branch
      issue        <= (i == 0) && (cap || held);
      issue_pc     <= row.pc ^ 32'h0000_0400;
      issue_funct3 <= F3_BEQ;
      issue_a      <= 32'd0;
      issue_b      <= 32'd0;
      @(negedge CLK);
      expect_bit("resolved", 1'b0, resolved);
    end
    @(posedge CLK);
    issue  <= 1'b0;
    enable <= 1'b1;
    @(negedge CLK);
    expect_bit("resolved", 1'b0, resolved);
    @(posedge CLK);
    @(negedge CLK);
    expect_bit("resolved", cap, resolved);
    expect_bit("redirect", cap && (taken != exp_pt), redirect);
    if (cap) begin
      expect_bit("resolved_taken", taken, resolved_taken);
      expect_word("resolved_pc", next_pc, resolved_pc);
      if (taken != exp_pt) expect_word("redirect_pc", next_pc, redirect_pc);
      model_update(row.pc, row.pc + row.imm, taken);
    end
    repeat (2) begin
      @(posedge CLK);
      @(negedge CLK);
      expect_bit("resolved", 1'b0, resolved);  // enable still high
    end
    @(posedge CLK);
    enable <= 1'b0;
    retire <= row.ret;
    @(posedge CLK);
    retire <= 1'b0;
    held = (cap || held) && !row.ret;
    @(negedge CLK);
    expect_bit("busy", held, busy);
    if (errors == err0) rows_ok++;
    else rows_bad++;
    $display("row %0d pc=%08h funct3=%03b dly=%0d : %s", r, row.pc, row.f3, row.dly,
             (errors == err0) ? "ok" : "mismatch");
  endtask

  initial begin
    int r;
    int max_dly;
    nRST         = 1'b0;
    issue        = 1'b0;
    issue_pc     = '0;
    issue_funct3 = F3_BEQ;
    issue_a      = '0;
    issue_b      = '0;
    issue_imm    = '0;
    enable       = 1'b0;
    retire       = 1'b0;
    errors       = 0;
    rows_ok      = 0;
    rows_bad     = 0;
    held         = 1'b0;
    m_valid      = '0;
    // pc, funct3, a, b, imm, dly, retire, taken
    add_row(32'h1010, F3_BEQ,  32'd5, 32'd5, 32'h20, 4'd0, 1'b1, 1'b1);  // allocate
    add_row(32'h1010, F3_BNE,  32'd5, 32'd5, 32'h20, 4'd2, 1'b1, 1'b0);
    add_row(32'h1010, F3_BLT,  32'hffff_ffff, 32'd1, 32'h20, 4'd1, 1'b1, 1'b1);
    add_row(32'h1010, F3_BLTU, 32'hffff_ffff, 32'd1, 32'h20, 4'd0, 1'b1, 1'b0);
    add_row(32'h1010, F3_BGE,  32'd1, 32'hffff_ffff, 32'h20, 4'd3, 1'b1, 1'b1);
    add_row(32'h1010, F3_BGEU, 32'hffff_ffff, 32'd1, 32'h20, 4'd1, 1'b1, 1'b1);
    add_row(32'h1010, F3_BEQ,  32'd7, 32'd7, 32'h20, 4'd2, 1'b0, 1'b1);  // stays held
    add_row(32'h2048, F3_BNE,  32'd1, 32'd2, 32'h10, 4'd1, 1'b1, 1'b1);  // dropped while busy
    add_row(32'h1010, 3'b010,  32'd0, 32'd0, 32'h20, 4'd0, 1'b1, 1'b0);  // not a branch
    add_row(32'h5010, F3_BLTU, 32'd1, 32'd2, 32'h100, 4'd4, 1'b1, 1'b1); // same index
    add_row(32'h1010, F3_BEQ,  32'd1, 32'd2, 32'h20, 4'd5, 1'b1, 1'b0);
    add_row(32'h5010, F3_BGEU, 32'h8000_0000, 32'h7fff_ffff, 32'hffff_fff8, 4'd2, 1'b1,
            1'b1);
    add_row(32'h3020, F3_BNE,  32'd3, 32'd4, 32'h40, 4'd1, 1'b1, 1'b1);
    add_row(32'h3020, F3_BLT,  32'h7fff_ffff, 32'h8000_0000, 32'h40, 4'd0, 1'b1, 1'b0);
    max_dly = 0;
    foreach (rows[k]) begin
      if (int'(rows[k].dly) > max_dly) begin
        max_dly = int'(rows[k].dly);
      end
    end
    limit = rows.size() * (max_dly + 8) + 40;
    repeat (16) @(posedge CLK);
    nRST <= 1'b1;
    @(negedge CLK);
    expect_bit("busy", 1'b0, busy);
    expect_bit("resolved", 1'b0, resolved);
    expect_bit("redirect", 1'b0, redirect);
    expect_bit("pred_taken", 1'b0, pred_taken);
    expect_word("pred_target", issue_pc + 32'd4, pred_target);
    for (r = 0; r < rows.size(); r++) begin
      run_row(r, rows[r]);
    end
    $display("rows passed %0d, rows failed %0d, check errors %0d", rows_ok, rows_bad, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== br_resolve.f ====
br_pkg.sv
br_predict.sv
br_operand.sv
fu_branch.sv
br_update.sv
br_top.sv
tb_br_top.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := tb_br_top
RTL_TOP    := br_top
FILELIST   := br_resolve.f
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_MSG   := ALL TESTS PASSED
VFLAGS     := --binary --timing --assert --timescale 1ns/1ps -j 0
LINT_FLAGS := --lint-only -Wall --timing --timescale 1ns/1ps

SOURCES    := $(shell cat $(FILELIST))
SIM_BIN    := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(SIM_BIN) | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
